// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vdp_tb -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vvdp_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== src/vdp_csr_regs.sv ====
`timescale 1ns/1ps

module vdp_csr_regs
  (
    input  logic               clk_i
  , input  logic               reset_i

  , input  logic               csr_we_i
  , input  logic               csr_re_i
  , input  vdp_pkg::csr_addr_t csr_addr_i
  , input  vdp_pkg::word_t     csr_wdata_i
  , output vdp_pkg::word_t     csr_rdata_o
  , output logic               csr_ack_o

  , input  logic               run_done_i
  , input  logic               idle_i

  , output logic               start_o
  , output vdp_pkg::addr_t     a_ptr_o
  , output vdp_pkg::addr_t     b_ptr_o
  , output vdp_pkg::addr_t     res_ptr_o
  , output vdp_pkg::word_t     len_o
  );

  vdp_pkg::addr_t a_ptr_q;
  vdp_pkg::addr_t b_ptr_q;
  vdp_pkg::addr_t res_ptr_q;
  vdp_pkg::word_t len_q;
  logic           start_q;
  vdp_pkg::word_t rdata_q;
  logic           ack_q;
  vdp_pkg::word_t rdata_d;

  // ==========================================================================
  // write decode
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_q   <= '0;
      b_ptr_q   <= '0;
      res_ptr_q <= '0;
      len_q     <= '0;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        vdp_pkg::CSR_A_PTR:   a_ptr_q   <= vdp_pkg::addr_t'(csr_wdata_i);
        vdp_pkg::CSR_B_PTR:   b_ptr_q   <= vdp_pkg::addr_t'(csr_wdata_i);
        vdp_pkg::CSR_LEN:     len_q     <= csr_wdata_i;
        vdp_pkg::CSR_RES_PTR: res_ptr_q <= vdp_pkg::addr_t'(csr_wdata_i);
        default: ;                                     // status is read only.
      endcase
    end
  end

  // start arms on any nonzero write, drops when the run ends.
  always_ff @(posedge clk_i) begin
    if (reset_i || run_done_i) begin
      start_q <= 1'b0;
    end else if (csr_we_i && csr_addr_i == vdp_pkg::CSR_START) begin
      start_q <= |csr_wdata_i;
    end
  end

  // ==========================================================================
  // read mux
  // ==========================================================================

  always_comb begin
    case (csr_addr_i)
      vdp_pkg::CSR_A_PTR:   rdata_d = vdp_pkg::word_t'(a_ptr_q);
      vdp_pkg::CSR_B_PTR:   rdata_d = vdp_pkg::word_t'(b_ptr_q);
      vdp_pkg::CSR_LEN:     rdata_d = len_q;
      vdp_pkg::CSR_START:   rdata_d = vdp_pkg::word_t'(start_q);
      vdp_pkg::CSR_STATUS:  rdata_d = vdp_pkg::word_t'(idle_i);
      vdp_pkg::CSR_RES_PTR: rdata_d = vdp_pkg::word_t'(res_ptr_q);
      default:              rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (csr_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= csr_we_i | csr_re_i;                    // one cycle later.
    end
  end

  assign csr_rdata_o = rdata_q;
  assign csr_ack_o   = ack_q;
  assign start_o     = start_q;
  assign a_ptr_o     = a_ptr_q;
  assign b_ptr_o     = b_ptr_q;
  assign res_ptr_o   = res_ptr_q;
  assign len_o       = len_q;

endmodule

// ==== src/vdp_ctrl_fsm.sv ====
`timescale 1ns/1ps

module vdp_ctrl_fsm
  (
    input  logic clk_i
  , input  logic reset_i
  , input  logic start_i
  , input  logic last_i

  , input  logic mem_ready_i
  , input  logic mem_rvalid_i

  , output logic mem_req_o
  , output logic mem_we_o
  , output logic cnt_clr_o
  , output logic cnt_inc_o
  , output logic sel_b_o
  , output logic st_sel_o
  , output logic buf_wr_o
  , output logic buf_clr_o
  , output logic res_cap_o
  , output logic run_done_o
  , output logic idle_o
  );

  vdp_pkg::state_e state_q;
  vdp_pkg::state_e state_d;
  logic            sel_b_q;  // fetching vector b.
  logic            st_sel_q; // result store phase.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= vdp_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || state_q == vdp_pkg::ST_DONE) begin
      sel_b_q  <= 1'b0;
      st_sel_q <= 1'b0;
    end else begin
      if (state_q == vdp_pkg::ST_SWITCH_B) sel_b_q <= 1'b1;
      if (state_q == vdp_pkg::ST_CAPTURE)  st_sel_q <= 1'b1;
    end
  end

  // ==========================================================================
  // next state and strobes
  // ==========================================================================

  always_comb begin
    state_d    = state_q;
    mem_req_o  = 1'b0;
    cnt_clr_o  = 1'b0;
    cnt_inc_o  = 1'b0;
    buf_wr_o   = 1'b0;
    buf_clr_o  = 1'b0;
    res_cap_o  = 1'b0;
    run_done_o = 1'b0;
    case (state_q)
      vdp_pkg::ST_IDLE: begin
        if (start_i) begin
          cnt_clr_o = 1'b1;
          state_d   = vdp_pkg::ST_WAIT_MEM;
        end
      end
      vdp_pkg::ST_WAIT_MEM: begin
        if (mem_ready_i) state_d = vdp_pkg::ST_ISSUE;
      end
      vdp_pkg::ST_ISSUE: begin
        // ready may have dropped since the last cycle.
        if (mem_ready_i) begin
          mem_req_o = 1'b1;
          state_d   = st_sel_q ? vdp_pkg::ST_STORE_WAIT : vdp_pkg::ST_WAIT_RESP;
        end else begin
          state_d = vdp_pkg::ST_WAIT_MEM;
        end
      end
      vdp_pkg::ST_WAIT_RESP: begin
        if (mem_rvalid_i) begin
          buf_wr_o  = 1'b1;                            // at the old index.
          cnt_inc_o = 1'b1;
          state_d   = vdp_pkg::ST_CHECK;
        end
      end
      vdp_pkg::ST_CHECK: begin
        if (!last_i) begin
          state_d = vdp_pkg::ST_WAIT_MEM;
        end else begin
          state_d = sel_b_q ? vdp_pkg::ST_CAPTURE : vdp_pkg::ST_SWITCH_B;
        end
      end
      vdp_pkg::ST_SWITCH_B: begin
        cnt_clr_o = 1'b1;
        state_d   = vdp_pkg::ST_WAIT_MEM;
      end
      vdp_pkg::ST_CAPTURE: begin
        res_cap_o = 1'b1;                              // both vectors loaded.
        state_d   = vdp_pkg::ST_WAIT_MEM;
      end
      vdp_pkg::ST_STORE_WAIT: begin
        if (mem_rvalid_i) begin
          run_done_o = 1'b1;
          buf_clr_o  = 1'b1;
          state_d    = vdp_pkg::ST_DONE;
        end
      end
      vdp_pkg::ST_DONE: state_d = vdp_pkg::ST_IDLE;
      default:          state_d = vdp_pkg::ST_IDLE;
    endcase
  end

  assign mem_we_o = mem_req_o & st_sel_q;
  assign sel_b_o  = sel_b_q;
  assign st_sel_o = st_sel_q;
  // busy as soon as start is seen.
  assign idle_o   = (state_q == vdp_pkg::ST_IDLE && !start_i) ||
                    state_q == vdp_pkg::ST_DONE;

endmodule

// ==== src/vdp_dot_tree.sv ====
`timescale 1ns/1ps

module vdp_dot_tree
  #(parameter int VEC_LEN = 8)
  (
    input  logic           clk_i
  , input  logic           reset_i
  , input  logic           cap_i

  , input  vdp_pkg::word_t vec_a_i [VEC_LEN]
  , input  vdp_pkg::word_t vec_b_i [VEC_LEN]

  , output vdp_pkg::word_t result_o
  );

  localparam int LEVELS = $clog2(VEC_LEN);

  vdp_pkg::word_t prod [VEC_LEN];
  vdp_pkg::word_t result_q;

  for (genvar i = 0; i < VEC_LEN; i++) begin : g_mul
    assign prod[i] = vec_a_i[i] * vec_b_i[i];          // low 64 bits.
  end

  // each level halves the number of partial sums.
  for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
    localparam int N = VEC_LEN >> (l + 1);
    vdp_pkg::word_t sum [N];
    for (genvar i = 0; i < N; i++) begin : g_add
      if (l == 0) begin : g_leaf
        assign sum[i] = prod[2*i] + prod[2*i+1];
      end else begin : g_node
        assign sum[i] = g_lvl[l-1].sum[2*i] + g_lvl[l-1].sum[2*i+1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
    end else if (cap_i) begin
      result_q <= g_lvl[LEVELS-1].sum[0];
    end
  end

  assign result_o = result_q;

endmodule

// ==== src/vdp_elem_counter.sv ====
`timescale 1ns/1ps

module vdp_elem_counter
  #(parameter int VEC_LEN = 8,
    localparam int IDX_W  = $clog2(VEC_LEN))
  (
    input  logic             clk_i
  , input  logic             reset_i
  , input  logic             clr_i
  , input  logic             inc_i
  , input  logic             sel_b_i
  , input  logic             st_sel_i

  , input  vdp_pkg::addr_t   a_ptr_i
  , input  vdp_pkg::addr_t   b_ptr_i
  , input  vdp_pkg::addr_t   res_ptr_i
  , input  vdp_pkg::word_t   len_i

  , output logic [IDX_W-1:0] idx_o
  , output logic             last_o
  , output vdp_pkg::addr_t   mem_addr_o
  );

  // one extra bit so the count can reach VEC_LEN.
  logic [IDX_W:0] cnt_q;
  vdp_pkg::addr_t base;

  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign idx_o  = cnt_q[IDX_W-1:0];
  assign last_o = vdp_pkg::word_t'(cnt_q) == len_i;

  assign base       = sel_b_i ? b_ptr_i : a_ptr_i;
  assign mem_addr_o = st_sel_i ? res_ptr_i
                               : base + vdp_pkg::addr_t'(cnt_q) * vdp_pkg::ELEM_BYTES;

endmodule

// ==== src/vdp_pkg.sv ====
package vdp_pkg;

  // ==========================================================================
  // data widths
  // ==========================================================================

  typedef logic [63:0] word_t;     // element, data word or register value.
  typedef logic [31:0] addr_t;     // byte address on the memory port.
  typedef logic [9:0]  csr_addr_t; // register offset.

  // ==========================================================================
  // register map
  // ==========================================================================

  localparam csr_addr_t CSR_A_PTR   = 10'h000;
  localparam csr_addr_t CSR_B_PTR   = 10'h040;
  localparam csr_addr_t CSR_LEN     = 10'h080;
  localparam csr_addr_t CSR_START   = 10'h0C0;
  localparam csr_addr_t CSR_STATUS  = 10'h100; // read only.
  localparam csr_addr_t CSR_RES_PTR = 10'h140;

  localparam addr_t ELEM_BYTES = 32'd8; // one 64-bit element.

  // ==========================================================================
  // run sequence
  // ==========================================================================

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WAIT_MEM,
    ST_ISSUE,
    ST_WAIT_RESP,
    ST_CHECK,
    ST_SWITCH_B,
    ST_CAPTURE,
    ST_STORE_WAIT,
    ST_DONE
  } state_e;

endpackage

// ==== src/vdp_top.sv ====
`timescale 1ns/1ps

module vdp_top
  #(parameter int VEC_LEN = 8)
  (
    input  logic               clk_i
  , input  logic               reset_i

  , input  logic               csr_we_i
  , input  logic               csr_re_i
  , input  vdp_pkg::csr_addr_t csr_addr_i
  , input  vdp_pkg::word_t     csr_wdata_i
  , output vdp_pkg::word_t     csr_rdata_o
  , output logic               csr_ack_o

  , input  logic               mem_ready_i
  , output logic               mem_req_o
  , output logic               mem_we_o
  , output vdp_pkg::addr_t     mem_addr_o
  , output vdp_pkg::word_t     mem_wdata_o
  , input  vdp_pkg::word_t     mem_rdata_i
  , input  logic               mem_rvalid_i
  );

  localparam int IDX_W = $clog2(VEC_LEN);

  logic           start;
  logic           run_done;
  logic           idle;
  vdp_pkg::addr_t a_ptr;
  vdp_pkg::addr_t b_ptr;
  vdp_pkg::addr_t res_ptr;
  vdp_pkg::word_t len;

  logic             cnt_clr;
  logic             cnt_inc;
  logic             sel_b;
  logic             st_sel;
  logic             last;
  logic [IDX_W-1:0] idx;

  logic           buf_wr;
  logic           buf_clr;
  logic           res_cap;
  vdp_pkg::word_t vec_a [VEC_LEN];
  vdp_pkg::word_t vec_b [VEC_LEN];

  vdp_csr_regs i_csr_regs (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .csr_we_i    (csr_we_i)
    , .csr_re_i    (csr_re_i)
    , .csr_addr_i  (csr_addr_i)
    , .csr_wdata_i (csr_wdata_i)
    , .csr_rdata_o (csr_rdata_o)
    , .csr_ack_o   (csr_ack_o)
    , .run_done_i  (run_done)
    , .idle_i      (idle)
    , .start_o     (start)
    , .a_ptr_o     (a_ptr)
    , .b_ptr_o     (b_ptr)
    , .res_ptr_o   (res_ptr)
    , .len_o       (len)
  );

  vdp_ctrl_fsm i_ctrl_fsm (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .start_i      (start)
    , .last_i       (last)
    , .mem_ready_i  (mem_ready_i)
    , .mem_rvalid_i (mem_rvalid_i)
    , .mem_req_o    (mem_req_o)
    , .mem_we_o     (mem_we_o)
    , .cnt_clr_o    (cnt_clr)
    , .cnt_inc_o    (cnt_inc)
    , .sel_b_o      (sel_b)
    , .st_sel_o     (st_sel)
    , .buf_wr_o     (buf_wr)
    , .buf_clr_o    (buf_clr)
    , .res_cap_o    (res_cap)
    , .run_done_o   (run_done)
    , .idle_o       (idle)
  );

  vdp_elem_counter #(.VEC_LEN(VEC_LEN)) i_elem_counter (
      .clk_i      (clk_i)
    , .reset_i    (reset_i)
    , .clr_i      (cnt_clr)
    , .inc_i      (cnt_inc)
    , .sel_b_i    (sel_b)
    , .st_sel_i   (st_sel)
    , .a_ptr_i    (a_ptr)
    , .b_ptr_i    (b_ptr)
    , .res_ptr_i  (res_ptr)
    , .len_i      (len)
    , .idx_o      (idx)
    , .last_o     (last)
    , .mem_addr_o (mem_addr_o)
  );

  vdp_vector_buf #(.VEC_LEN(VEC_LEN)) i_vector_buf (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .wr_i    (buf_wr)
    , .clr_i   (buf_clr)
    , .sel_b_i (sel_b)
    , .idx_i   (idx)
    , .data_i  (mem_rdata_i)
    , .vec_a_o (vec_a)
    , .vec_b_o (vec_b)
  );

  vdp_dot_tree #(.VEC_LEN(VEC_LEN)) i_dot_tree (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .cap_i    (res_cap)
    , .vec_a_i  (vec_a)
    , .vec_b_i  (vec_b)
    , .result_o (mem_wdata_o)
  );

endmodule

// ==== src/vdp_vector_buf.sv ====
`timescale 1ns/1ps

module vdp_vector_buf
  #(parameter int VEC_LEN = 8,
    localparam int IDX_W  = $clog2(VEC_LEN))
  (
    input  logic             clk_i
  , input  logic             reset_i
  , input  logic             wr_i
  , input  logic             clr_i
  , input  logic             sel_b_i

  , input  logic [IDX_W-1:0] idx_i
  , input  vdp_pkg::word_t   data_i

  , output vdp_pkg::word_t   vec_a_o [VEC_LEN]
  , output vdp_pkg::word_t   vec_b_o [VEC_LEN]
  );

  vdp_pkg::word_t vec_a_q [VEC_LEN];
  vdp_pkg::word_t vec_b_q [VEC_LEN];

  // ==========================================================================
  // operand storage
  // ==========================================================================

  // zeroed entries drop out of a shorter run's sum.
  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      vec_a_q <= '{default: '0};
      vec_b_q <= '{default: '0};
    end else if (wr_i) begin
      if (sel_b_i) begin
        vec_b_q[idx_i] <= data_i;
      end else begin
        vec_a_q[idx_i] <= data_i;
      end
    end
  end

  assign vec_a_o = vec_a_q;
  assign vec_b_o = vec_b_q;

endmodule

// ==== tb.f ====
src/vdp_pkg.sv
src/vdp_csr_regs.sv
src/vdp_ctrl_fsm.sv
src/vdp_elem_counter.sv
src/vdp_vector_buf.sv
src/vdp_dot_tree.sv
src/vdp_top.sv
tb/vdp_clk_gen.sv
tb/vdp_assert.sv
tb/vdp_tb.sv

// ==== tb/vdp_assert.sv ====
`timescale 1ns/1ps

module vdp_assert
  (
    input logic clk_i
  , input logic reset_i
  , input logic mem_ready_i
  , input logic mem_req_o
  , input logic mem_rvalid_i
  , input logic csr_we_i
  , input logic csr_re_i
  , input logic csr_ack_o
  );

  logic outstanding_q;                                 // access in flight.
  int   fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_o) begin
      outstanding_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // ==========================================================================
  // memory port
  // ==========================================================================

  req_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |-> mem_ready_i)
    else begin
      fail_cnt++;
      $error("memory request while ready is low");
    end

  one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |-> !outstanding_q)
    else begin
      fail_cnt++;
      $error("new memory request before the previous response");
    end

  // ==========================================================================
  // register port
  // ==========================================================================

  ack_after_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    (csr_we_i || csr_re_i) |=> csr_ack_o)
    else begin
      fail_cnt++;
      $error("register strobe not acknowledged one cycle later");
    end

  ack_only_after_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_ack_o |-> $past(csr_we_i || csr_re_i))
    else begin
      fail_cnt++;
      $error("register acknowledge without a strobe");
    end

endmodule

bind vdp_top vdp_assert i_vdp_assert (
    .clk_i        (clk_i)
  , .reset_i      (reset_i)
  , .mem_ready_i  (mem_ready_i)
  , .mem_req_o    (mem_req_o)
  , .mem_rvalid_i (mem_rvalid_i)
  , .csr_we_i     (csr_we_i)
  , .csr_re_i     (csr_re_i)
  , .csr_ack_o    (csr_ack_o)
);

// ==== tb/vdp_clk_gen.sv ====
`timescale 1ns/1ps

module vdp_clk_gen
  #(parameter int RESET_CYCLES = 4)
  (
    output logic clk_o
  , output logic reset_o
  );

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;                         // 10 ns period.
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// ==== tb/vdp_tb.sv ====
`timescale 1ns/1ps

module vdp_tb;

  localparam int VEC_LEN   = 8;
  localparam int MEM_WORDS = 256;
  // two runs of 2*VEC_LEN+1 accesses with room for ready gaps, plus register traffic.
  localparam int TIMEOUT_CYCLES = 2 * (2 * VEC_LEN + 1) * 500 + 3000;

  logic               clk;
  logic               reset;
  logic               csr_we;
  logic               csr_re;
  vdp_pkg::csr_addr_t csr_addr;
  vdp_pkg::word_t     csr_wdata;
  vdp_pkg::word_t     csr_rdata;
  logic               csr_ack;
  logic               mem_ready;
  logic               mem_req;
  logic               mem_we;
  vdp_pkg::addr_t     mem_addr;
  vdp_pkg::word_t     mem_wdata;
  vdp_pkg::word_t     mem_rdata;
  logic               mem_rvalid;

  vdp_pkg::word_t mem_q [MEM_WORDS];
  vdp_pkg::addr_t load_addr_q [$];
  vdp_pkg::addr_t store_addr_q [$];
  vdp_pkg::word_t store_data_q [$];
  vdp_pkg::addr_t exp_addr_q [$];
  vdp_pkg::word_t exp_data_q [$];

  logic [31:0] stim_rng;
  logic [31:0] mem_rng;
  logic        pending;
  logic        pend_store;
  logic        req_seen;
  logic [1:0]  lat_cnt;
  logic [7:0]  pend_idx;
  int          store_acks;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          cycle_cnt = 0;

  vdp_clk_gen i_clk_gen (
      .clk_o   (clk)
    , .reset_o (reset)
  );

  vdp_top #(.VEC_LEN(VEC_LEN)) i_vdp_top (
      .clk_i        (clk)
    , .reset_i      (reset)
    , .csr_we_i     (csr_we)
    , .csr_re_i     (csr_re)
    , .csr_addr_i   (csr_addr)
    , .csr_wdata_i  (csr_wdata)
    , .csr_rdata_o  (csr_rdata)
    , .csr_ack_o    (csr_ack)
    , .mem_ready_i  (mem_ready)
    , .mem_req_o    (mem_req)
    , .mem_we_o     (mem_we)
    , .mem_addr_o   (mem_addr)
    , .mem_wdata_o  (mem_wdata)
    , .mem_rdata_i  (mem_rdata)
    , .mem_rvalid_i (mem_rvalid)
  );

  // ==========================================================================
  // reference and checks
  // ==========================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic vdp_pkg::word_t dot_ref(input vdp_pkg::word_t a [VEC_LEN],
                                             input vdp_pkg::word_t b [VEC_LEN],
                                             input int len);
    vdp_pkg::word_t sum;
    vdp_pkg::word_t prod;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      prod = a[i] * b[i];                              // low 64 bits only.
      sum  = sum + prod;                               // wraps modulo 2^64.
    end
    return sum;
  endfunction

  task automatic check_word(input string name, input vdp_pkg::word_t got,
                            input vdp_pkg::word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input vdp_pkg::addr_t got,
                            input vdp_pkg::addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // ==========================================================================
  // register port
  // ==========================================================================

  task automatic wait_ack();
    int n;
    n = 0;
    while (csr_ack !== 1'b1 && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (csr_ack !== 1'b1) begin
      err_cnt++;
      $display("register access at %0t ns got no acknowledge", $time);
    end
  endtask

  task automatic write_reg(input vdp_pkg::csr_addr_t addr, input vdp_pkg::word_t data);
    @(negedge clk);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_we = 1'b0;
    wait_ack();
  endtask

  task automatic read_reg(input vdp_pkg::csr_addr_t addr, output vdp_pkg::word_t data);
    @(negedge clk);
    csr_re   = 1'b1;
    csr_addr = addr;
    @(negedge clk);
    csr_re = 1'b0;
    wait_ack();
    data = csr_rdata;
  endtask

  task automatic draw_word(output vdp_pkg::word_t w);
    stim_rng = lcg_next(stim_rng);
    w[63:32] = stim_rng;
    stim_rng = lcg_next(stim_rng);
    w[31:0]  = stim_rng;
  endtask

  // ==========================================================================
  // memory model and result compare
  // ==========================================================================

  always @(negedge clk) begin
    req_seen   = mem_req;
    mem_rvalid = 1'b0;
    if (!reset) begin
      if (pending) begin
        if (lat_cnt == 2'd0) begin
          mem_rvalid = 1'b1;
          mem_rdata  = mem_q[pend_idx];
          pending    = 1'b0;
          if (pend_store) begin
            store_acks++;
          end
        end else begin
          lat_cnt = lat_cnt - 2'd1;
        end
      end else if (req_seen) begin
        pending    = 1'b1;
        pend_store = mem_we;
        pend_idx   = mem_addr[10:3];
        mem_rng    = lcg_next(mem_rng);
        lat_cnt    = mem_rng[17:16];                   // 1 to 4 cycles.
        if (mem_we) begin
          mem_q[pend_idx] = mem_wdata;
          store_addr_q.push_back(mem_addr);
          store_data_q.push_back(mem_wdata);
        end else begin
          load_addr_q.push_back(mem_addr);
        end
      end
      // ready holds while a request is on the port.
      if (!req_seen) begin
        mem_rng   = lcg_next(mem_rng);
        mem_ready = mem_rng[20:19] != 2'b00;
      end
    end
  end

  always @(negedge clk) begin
    if (store_addr_q.size() > 0) begin
      if (exp_data_q.size() == 0) begin
        err_cnt++;
        $display("store to %h at %0t ns with no run expected", store_addr_q[0], $time);
        store_addr_q.delete();
        store_data_q.delete();
      end else begin
        check_addr("mem_addr_o", store_addr_q.pop_front(), exp_addr_q.pop_front());
        check_word("mem_wdata_o", store_data_q.pop_front(), exp_data_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic reg_access_test();
    vdp_pkg::word_t rd;
    int             errs;
    errs = err_cnt;
    read_reg(vdp_pkg::CSR_STATUS, rd);
    check_word("status", rd, 64'd1);
    read_reg(vdp_pkg::CSR_A_PTR, rd);
    check_word("a_ptr", rd, 64'd0);
    read_reg(vdp_pkg::CSR_B_PTR, rd);
    check_word("b_ptr", rd, 64'd0);
    read_reg(vdp_pkg::CSR_RES_PTR, rd);
    check_word("res_ptr", rd, 64'd0);
    write_reg(vdp_pkg::CSR_A_PTR, 64'h0000_0000_1234_5678);
    write_reg(vdp_pkg::CSR_B_PTR, 64'h0000_0000_8765_4320);
    write_reg(vdp_pkg::CSR_LEN, 64'hfedc_ba98_0000_0005);
    write_reg(vdp_pkg::CSR_RES_PTR, 64'h0000_0000_0000_0abc);
    read_reg(vdp_pkg::CSR_A_PTR, rd);
    check_word("a_ptr", rd, 64'h0000_0000_1234_5678);
    read_reg(vdp_pkg::CSR_B_PTR, rd);
    check_word("b_ptr", rd, 64'h0000_0000_8765_4320);
    read_reg(vdp_pkg::CSR_LEN, rd);
    check_word("len", rd, 64'hfedc_ba98_0000_0005);
    read_reg(vdp_pkg::CSR_RES_PTR, rd);
    check_word("res_ptr", rd, 64'h0000_0000_0000_0abc);
    write_reg(vdp_pkg::CSR_STATUS, 64'd0);             // read only.
    read_reg(vdp_pkg::CSR_STATUS, rd);
    check_word("status", rd, 64'd1);
    read_reg(10'h3c0, rd);
    check_word("unknown offset", rd, 64'd0);
    report_test("register access", errs);
  endtask

  task automatic dot_run_test(input string name, input int len, input vdp_pkg::addr_t a_ptr,
                              input vdp_pkg::addr_t b_ptr, input vdp_pkg::addr_t res_ptr);
    vdp_pkg::word_t a [VEC_LEN];
    vdp_pkg::word_t b [VEC_LEN];
    vdp_pkg::word_t rd;
    logic [7:0]     a_idx;
    logic [7:0]     b_idx;
    logic           busy_seen;
    int             acks;
    int             errs;
    errs  = err_cnt;
    a_idx = a_ptr[10:3];
    b_idx = b_ptr[10:3];
    // the whole window is filled so that over-fetching shows.
    for (int i = 0; i < VEC_LEN; i++) begin
      draw_word(a[i]);
      draw_word(b[i]);
      mem_q[a_idx + 8'(i)] = a[i];
      mem_q[b_idx + 8'(i)] = b[i];
    end
    exp_data_q.push_back(dot_ref(a, b, len));
    exp_addr_q.push_back(res_ptr);
    load_addr_q.delete();
    write_reg(vdp_pkg::CSR_A_PTR, vdp_pkg::word_t'(a_ptr));
    write_reg(vdp_pkg::CSR_B_PTR, vdp_pkg::word_t'(b_ptr));
    write_reg(vdp_pkg::CSR_LEN, vdp_pkg::word_t'(len));
    write_reg(vdp_pkg::CSR_RES_PTR, vdp_pkg::word_t'(res_ptr));
    acks      = store_acks;
    busy_seen = 1'b0;
    write_reg(vdp_pkg::CSR_START, 64'd1);
    while (store_acks == acks) begin
      read_reg(vdp_pkg::CSR_STATUS, rd);
      if (rd == 64'd0) begin
        busy_seen = 1'b1;
      end
    end
    if (!busy_seen) begin
      err_cnt++;
      $display("status never read busy during the %s run", name);
    end
    read_reg(vdp_pkg::CSR_STATUS, rd);
    check_word("status", rd, 64'd1);
    read_reg(vdp_pkg::CSR_START, rd);
    check_word("start", rd, 64'd0);
    if (load_addr_q.size() != 2 * len) begin
      err_cnt++;
      $display("expected %0d loads, memory saw %0d", 2 * len, load_addr_q.size());
    end else begin
      for (int i = 0; i < len; i++) begin
        check_addr("mem_addr_o", load_addr_q[i], a_ptr + vdp_pkg::addr_t'(i) * 32'd8);
      end
      for (int i = 0; i < len; i++) begin
        check_addr("mem_addr_o", load_addr_q[len + i], b_ptr + vdp_pkg::addr_t'(i) * 32'd8);
      end
    end
    report_test(name, errs);
  endtask

  initial begin
    vdp_pkg::addr_t fill_addr;
    csr_we     = 1'b0;
    csr_re     = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    mem_ready  = 1'b1;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    stim_rng   = 32'd2;
    mem_rng    = 32'd2;
    pending    = 1'b0;
    pend_store = 1'b0;
    req_seen   = 1'b0;
    lat_cnt    = '0;
    pend_idx   = '0;
    store_acks = 0;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      fill_addr      = vdp_pkg::addr_t'(i) * 32'd8;
      mem_q[8'(i)]   = {~fill_addr, fill_addr};
    end
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end

    reg_access_test();
    dot_run_test("full length run", VEC_LEN, 32'h0000_0100, 32'h0000_0400, 32'h0000_0700);
    dot_run_test("length 3 run", 3, 32'h0000_0180, 32'h0000_0480, 32'h0000_0708);

    if (exp_data_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected stores never reached memory", exp_data_q.size());
    end
    err_cnt = err_cnt + i_vdp_top.i_vdp_assert.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
